/* logic/board_bus_params.svh */
`ifndef BOARD_BUS_PARAMS_SVH
`define BOARD_BUS_PARAMS_SVH

// bus widths
`define BB_ADDR_W 16
`define BB_DATA_W 32

// data RAM, 4 KiB of 32-bit words
`define BB_RAM_WORDS 1024
`define BB_RAM_BASE 16'h0000

// keyboard registers
`define BB_KEY_CODE_ADDR 16'h2000
`define BB_KEY_ACK_ADDR 16'h2004

// sector cache, one byte per word slot
`define BB_SEC_BASE 16'h3000
`define BB_SEC_AVAIL_ADDR 16'h3800
`define BB_SEC_BYTES 512

// AXI response codes
`define BB_RESP_OKAY 2'b00
`define BB_RESP_DECERR 2'b11

`endif

/* logic/board_bus_pkg.sv */
`default_nettype none
`include "board_bus_params.svh"

package board_bus_pkg;

    // bus payload types
    typedef logic [`BB_ADDR_W-1:0] bus_addr_t;
    typedef logic [`BB_DATA_W-1:0] bus_data_t;
    typedef logic [`BB_DATA_W/8-1:0] bus_strb_t;
    typedef logic [1:0] axi_resp_t;

    // peripheral side
    typedef logic [7:0] key_code_t;
    typedef logic [$clog2(`BB_SEC_BYTES)-1:0] sec_index_t;
    typedef logic [$clog2(`BB_RAM_WORDS)-1:0] ram_index_t;

    // decoded address regions
    typedef enum logic [2:0] {
        REG_RAM,
        REG_KEY_CODE,
        REG_KEY_ACK,
        REG_SEC,
        REG_SEC_AVAIL,
        REG_UNMAPPED
    } region_e;

    // read channel of the slave port
    typedef enum logic {RD_IDLE, RD_WAIT} rd_state_e;

endpackage

`default_nettype wire

/* logic/axil_slave_port.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_slave_port (
    input  logic                      clock_50,
    input  logic                      key0,
    // AXI4-Lite write address and data
    input  board_bus_pkg::bus_addr_t  awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  board_bus_pkg::bus_data_t  wdata,
    input  board_bus_pkg::bus_strb_t  wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    // AXI4-Lite write response
    output board_bus_pkg::axi_resp_t  bresp,
    output logic                      bvalid,
    input  logic                      bready,
    // AXI4-Lite read
    input  board_bus_pkg::bus_addr_t  araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output board_bus_pkg::bus_data_t  rdata,
    output board_bus_pkg::axi_resp_t  rresp,
    output logic                      rvalid,
    input  logic                      rready,
    // router side
    output logic                      wr_req,
    output board_bus_pkg::bus_addr_t  wr_addr,
    output board_bus_pkg::bus_data_t  wr_data,
    output board_bus_pkg::bus_strb_t  wr_strb,
    input  board_bus_pkg::axi_resp_t  wr_resp,
    output logic                      rd_req,
    output board_bus_pkg::bus_addr_t  rd_addr,
    input  board_bus_pkg::bus_data_t  rd_data,
    input  board_bus_pkg::axi_resp_t  rd_resp
);

    board_bus_pkg::rd_state_e rd_state;
    logic wr_busy;
    logic wr_fire;
    logic wr_load;
    logic rd_fire;
    logic rd_due;
    logic rd_load;

    // address and data taken together, blocked until the response is gone
    assign awready = awvalid && wvalid && !wr_busy;
    assign wready  = awready;
    assign wr_fire = awvalid && wvalid && awready && wready;
    // one read in flight at a time
    assign arready = arvalid && (rd_state == board_bus_pkg::RD_IDLE);
    assign rd_fire = arvalid && arready;

    always_ff @(posedge clock_50 or negedge key0) begin
        if (!key0) begin
            wr_busy  <= 1'b0;
            wr_req   <= 1'b0;
            wr_load  <= 1'b0;
            bvalid   <= 1'b0;
            rd_state <= board_bus_pkg::RD_IDLE;
            rd_req   <= 1'b0;
            rd_due   <= 1'b0;
            rd_load  <= 1'b0;
            rvalid   <= 1'b0;
        end else begin
            // write pipe: request, response capture, bvalid
            wr_req  <= wr_fire;
            wr_load <= wr_req;
            if (wr_fire) begin
                wr_busy <= 1'b1;
            end else if (bvalid && bready) begin
                wr_busy <= 1'b0;
            end
            if (wr_load) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            // read pipe: request, router latency, data capture, rvalid
            rd_req  <= rd_fire;
            rd_due  <= rd_req;
            rd_load <= rd_due;
            case (rd_state)
                board_bus_pkg::RD_IDLE: if (rd_fire) rd_state <= board_bus_pkg::RD_WAIT;
                board_bus_pkg::RD_WAIT: if (rvalid && rready) rd_state <= board_bus_pkg::RD_IDLE;
                default: rd_state <= board_bus_pkg::RD_IDLE;
            endcase
            if (rd_load) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // held request and response payloads
    always_ff @(posedge clock_50) begin
        if (wr_fire) begin
            wr_addr <= awaddr;
            wr_data <= wdata;
            wr_strb <= wstrb;
        end
        if (wr_req) bresp <= wr_resp;
        if (rd_fire) rd_addr <= araddr;
        // router data is valid one cycle after rd_req
        if (rd_due) begin
            rdata <= rd_data;
            rresp <= rd_resp;
        end
    end

endmodule

`default_nettype wire

/* logic/memory_map_router.sv */
`timescale 1ns/1ps
`default_nettype none
`include "board_bus_params.svh"

module memory_map_router (
    input  logic                       clock_50,
    input  logic                       key0,
    input  logic                       wr_req,
    input  board_bus_pkg::bus_addr_t   wr_addr,
    input  board_bus_pkg::bus_data_t   wr_data,
    input  board_bus_pkg::bus_strb_t   wr_strb,
    output board_bus_pkg::axi_resp_t   wr_resp,
    input  logic                       rd_req,
    input  board_bus_pkg::bus_addr_t   rd_addr,
    output board_bus_pkg::bus_data_t   rd_data,
    output board_bus_pkg::axi_resp_t   rd_resp,
    output logic                       ram_we,
    output board_bus_pkg::bus_strb_t   ram_strb,
    output board_bus_pkg::ram_index_t  ram_index,
    output board_bus_pkg::bus_data_t   ram_wdata,
    input  board_bus_pkg::bus_data_t   ram_rdata,
    output logic                       key_ack,
    input  board_bus_pkg::key_code_t   key_code,
    output board_bus_pkg::sec_index_t  rd_index,
    input  logic [7:0]                 rd_byte,
    input  logic                       sec_avail
);

    localparam int RAM_IW = $bits(board_bus_pkg::ram_index_t);
    localparam int SEC_IW = $bits(board_bus_pkg::sec_index_t);

    function automatic board_bus_pkg::region_e decode(input board_bus_pkg::bus_addr_t addr);
        board_bus_pkg::bus_addr_t ram_off;
        board_bus_pkg::bus_addr_t sec_off;
        ram_off = addr - `BB_RAM_BASE;
        sec_off = addr - `BB_SEC_BASE;
        if (ram_off < board_bus_pkg::bus_addr_t'(`BB_RAM_WORDS * 4)) return board_bus_pkg::REG_RAM;
        if (addr == `BB_KEY_CODE_ADDR) return board_bus_pkg::REG_KEY_CODE;
        if (addr == `BB_KEY_ACK_ADDR) return board_bus_pkg::REG_KEY_ACK;
        if (sec_off < board_bus_pkg::bus_addr_t'(`BB_SEC_BYTES * 4)) return board_bus_pkg::REG_SEC;
        if (addr == `BB_SEC_AVAIL_ADDR) return board_bus_pkg::REG_SEC_AVAIL;
        return board_bus_pkg::REG_UNMAPPED;
    endfunction

    board_bus_pkg::region_e    wr_region;
    board_bus_pkg::region_e    rd_region;
    board_bus_pkg::region_e    rd_region_q;
    board_bus_pkg::bus_addr_t  wr_ram_off;
    board_bus_pkg::bus_addr_t  rd_ram_off;
    board_bus_pkg::bus_addr_t  rd_sec_off;
    logic                      rd_ram;
    // staged RAM write, waits out a colliding read
    logic                      wr_pend;
    board_bus_pkg::ram_index_t pend_index;
    board_bus_pkg::bus_data_t  pend_data;
    board_bus_pkg::bus_strb_t  pend_strb;

    assign wr_region  = decode(wr_addr);
    assign rd_region  = decode(rd_addr);
    assign wr_ram_off = wr_addr - `BB_RAM_BASE;
    assign rd_ram_off = rd_addr - `BB_RAM_BASE;
    assign rd_sec_off = rd_addr - `BB_SEC_BASE;
    assign rd_ram     = rd_req && (rd_region == board_bus_pkg::REG_RAM);
    assign rd_index   = rd_sec_off[SEC_IW+1:2];

    // RAM port, reads take priority
    assign ram_we    = wr_pend && !rd_ram;
    assign ram_index = rd_ram ? rd_ram_off[RAM_IW+1:2] : pend_index;
    assign ram_strb  = pend_strb;
    assign ram_wdata = pend_data;

    // mapped writes other than RAM and ack are dropped
    assign wr_resp = (wr_region == board_bus_pkg::REG_UNMAPPED) ? `BB_RESP_DECERR : `BB_RESP_OKAY;
    assign key_ack = wr_req && (wr_region == board_bus_pkg::REG_KEY_ACK);

    always_ff @(posedge clock_50 or negedge key0) begin
        if (!key0) begin
            wr_pend     <= 1'b0;
            rd_region_q <= board_bus_pkg::REG_UNMAPPED;
        end else begin
            if (wr_req && wr_region == board_bus_pkg::REG_RAM) begin
                wr_pend <= 1'b1;
            end else if (ram_we) begin
                wr_pend <= 1'b0;
            end
            if (rd_req) rd_region_q <= rd_region;
        end
    end

    always_ff @(posedge clock_50) begin
        if (wr_req) begin
            pend_index <= wr_ram_off[RAM_IW+1:2];
            pend_data  <= wr_data;
            pend_strb  <= wr_strb;
        end
    end

    // read data mux, one cycle after rd_req
    always_comb begin
        rd_data = '0;
        rd_resp = `BB_RESP_OKAY;
        case (rd_region_q)
            board_bus_pkg::REG_RAM:       rd_data = ram_rdata;
            board_bus_pkg::REG_KEY_CODE:  rd_data = board_bus_pkg::bus_data_t'(key_code);
            board_bus_pkg::REG_SEC:       rd_data = board_bus_pkg::bus_data_t'(rd_byte);
            board_bus_pkg::REG_SEC_AVAIL: rd_data = board_bus_pkg::bus_data_t'(sec_avail);
            board_bus_pkg::REG_UNMAPPED:  rd_resp = `BB_RESP_DECERR;
            default:                      rd_data = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none
`include "board_bus_params.svh"

module data_ram (
    input  logic                       clock_50,
    input  logic                       ram_we,
    input  board_bus_pkg::bus_strb_t   ram_strb,
    input  board_bus_pkg::ram_index_t  ram_index,
    input  board_bus_pkg::bus_data_t   ram_wdata,
    output board_bus_pkg::bus_data_t   ram_rdata
);

    localparam int LANES = $bits(board_bus_pkg::bus_strb_t);

    // single-port block RAM, read-first
    board_bus_pkg::bus_data_t mem [0:`BB_RAM_WORDS-1];

    // registered read, sees the word before a same-cycle write
    always_ff @(posedge clock_50) begin
        ram_rdata <= mem[ram_index];
    end

    // byte lanes written under their strobe bit
    always_ff @(posedge clock_50) begin
        if (ram_we) begin
            for (int b = 0; b < LANES; b++) begin
                if (ram_strb[b]) begin
                    mem[ram_index][8*b +: 8] <= ram_wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/key_irq_latch.sv */
`timescale 1ns/1ps
`default_nettype none

module key_irq_latch (
    input  logic                      clock_50,
    input  logic                      key0,
    input  logic                      key_strobe,
    input  board_bus_pkg::key_code_t  key_code_in,
    input  logic                      key_ack,
    output board_bus_pkg::key_code_t  key_code,
    output logic                      key_irq
);

    logic strobe_d;
    logic key_hit;

    // rising strobe with a real character, code 0 means no key
    assign key_hit = key_strobe && !strobe_d && (key_code_in != '0);

    always_ff @(posedge clock_50 or negedge key0) begin
        if (!key0) begin
            strobe_d <= 1'b0;
            key_code <= '0;
            key_irq  <= 1'b0;
        end else begin
            strobe_d <= key_strobe;
            // new key wins over a same-cycle ack
            if (key_hit) begin
                key_code <= key_code_in;
                key_irq  <= 1'b1;
            end else if (key_ack) begin
                key_irq  <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/sector_capture.sv */
`timescale 1ns/1ps
`default_nettype none
`include "board_bus_params.svh"

module sector_capture (
    input  logic                       clock_50,
    input  logic                       key0,
    input  logic                       sd_byte_valid,
    input  logic [7:0]                 sd_byte,
    output logic                       wr_en,
    output board_bus_pkg::sec_index_t  wr_index,
    output logic [7:0]                 wr_byte,
    output logic                       sec_avail
);

    logic                      valid_q;
    logic                      valid_d;
    logic [7:0]                byte_q;
    board_bus_pkg::sec_index_t idx;
    logic                      last_byte;

    // byte goes in on the rising edge of the registered valid
    assign wr_en     = valid_q && !valid_d;
    assign wr_index  = idx;
    assign wr_byte   = byte_q;
    assign last_byte = (idx == board_bus_pkg::sec_index_t'(`BB_SEC_BYTES - 1));

    always_ff @(posedge clock_50 or negedge key0) begin
        if (!key0) begin
            valid_q   <= 1'b0;
            valid_d   <= 1'b0;
            idx       <= '0;
            sec_avail <= 1'b0;
        end else begin
            valid_q <= sd_byte_valid;
            valid_d <= valid_q;
            if (wr_en) begin
                // index wraps at the sector end
                idx       <= idx + 1'b1;
                // set by the last byte, cleared by the next sector's first
                sec_avail <= last_byte;
            end
        end
    end

    // sampled with valid so the pair stays aligned
    always_ff @(posedge clock_50) begin
        byte_q <= sd_byte;
    end

endmodule

`default_nettype wire

/* logic/sector_cache.sv */
`timescale 1ns/1ps
`default_nettype none
`include "board_bus_params.svh"

module sector_cache (
    input  logic                       clock_50,
    input  logic                       wr_en,
    input  board_bus_pkg::sec_index_t  wr_index,
    input  logic [7:0]                 wr_byte,
    input  board_bus_pkg::sec_index_t  rd_index,
    output logic [7:0]                 rd_byte
);

    // one sector of bytes
    logic [7:0] mem [0:`BB_SEC_BYTES-1];

    // producer port, from the SD byte capture
    always_ff @(posedge clock_50) begin
        if (wr_en) begin
            mem[wr_index] <= wr_byte;
        end
    end

    // consumer port, registered read for the bus
    always_ff @(posedge clock_50) begin
        rd_byte <= mem[rd_index];
    end

endmodule

`default_nettype wire

/* logic/board_bus_top.sv */
`timescale 1ns/1ps
`default_nettype none

module board_bus_top (
    input  logic                      clock_50,
    input  logic                      key0,
    // AXI4-Lite slave
    input  board_bus_pkg::bus_addr_t  awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  board_bus_pkg::bus_data_t  wdata,
    input  board_bus_pkg::bus_strb_t  wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output board_bus_pkg::axi_resp_t  bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  board_bus_pkg::bus_addr_t  araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output board_bus_pkg::bus_data_t  rdata,
    output board_bus_pkg::axi_resp_t  rresp,
    output logic                      rvalid,
    input  logic                      rready,
    // keyboard decoder side
    input  logic                      key_strobe,
    input  board_bus_pkg::key_code_t  key_code_in,
    output logic                      key_irq,
    // SD byte stream
    input  logic                      sd_byte_valid,
    input  logic [7:0]                sd_byte,
    output logic                      sec_avail
);

    // port to router
    logic                      wr_req;
    board_bus_pkg::bus_addr_t  wr_addr;
    board_bus_pkg::bus_data_t  wr_data;
    board_bus_pkg::bus_strb_t  wr_strb;
    board_bus_pkg::axi_resp_t  wr_resp;
    logic                      rd_req;
    board_bus_pkg::bus_addr_t  rd_addr;
    board_bus_pkg::bus_data_t  rd_data;
    board_bus_pkg::axi_resp_t  rd_resp;
    // router to RAM
    logic                      ram_we;
    board_bus_pkg::bus_strb_t  ram_strb;
    board_bus_pkg::ram_index_t ram_index;
    board_bus_pkg::bus_data_t  ram_wdata;
    board_bus_pkg::bus_data_t  ram_rdata;
    // keyboard and sector paths
    logic                      key_ack;
    board_bus_pkg::key_code_t  key_code;
    board_bus_pkg::sec_index_t rd_index;
    logic [7:0]                rd_byte;
    logic                      wr_en;
    board_bus_pkg::sec_index_t wr_index;
    logic [7:0]                wr_byte;

    // net names match the port names throughout
    axil_slave_port   u_port    (.*);
    memory_map_router u_router  (.*);
    data_ram          u_ram     (.*);
    key_irq_latch     u_key     (.*);
    // producer, buffer
    sector_capture    u_capture (.*);
    sector_cache      u_cache   (.*);

endmodule

`default_nettype wire

/* verif/axil_bfm_tasks.svh */
`ifndef AXIL_BFM_TASKS_SVH
`define AXIL_BFM_TASKS_SVH

// one AXI4-Lite write, bready kept low for hold cycles once bvalid is up
task automatic write_word(
    input  string                     name,
    input  board_bus_pkg::bus_addr_t  addr,
    input  board_bus_pkg::bus_data_t  data,
    input  board_bus_pkg::bus_strb_t  strb,
    input  int                        hold,
    output board_bus_pkg::axi_resp_t  resp
);
    int lat;
    int tries;
    board_bus_pkg::axi_resp_t held;
    @(negedge clock_50);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    tries   = 0;
    // ready is combinational on the valids, let it settle
    #1;
    while (!(awready && wready)) begin
        if (tries == TIMEOUT) report_stall(name, "write address and data never accepted");
        @(negedge clock_50);
        #1;
        tries++;
    end
    // handshake on the coming rising edge
    @(negedge clock_50);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    lat     = 0;
    while (!bvalid) begin
        if (lat == TIMEOUT) report_stall(name, "write response never came");
        @(negedge clock_50);
        lat++;
    end
    check_word($sformatf("%s latency", name), 32'd2, 32'(lat));
    held = bresp;
    // second write must wait behind the pending response
    if (hold > 0) begin
        awvalid = 1'b1;
        wvalid  = 1'b1;
    end
    // back-pressure, response must stay put
    repeat (hold) begin
        @(negedge clock_50);
        assert (bvalid) else report_stall(name, "bvalid dropped while bready was low");
        assert (!awready) else report_stall(name, "awready rose with a write response pending");
        check_resp($sformatf("%s held bresp", name), held, bresp);
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    resp    = bresp;
    bready  = 1'b1;
    @(negedge clock_50);
    bready = 1'b0;
    assert (!bvalid) else report_stall(name, "bvalid stayed high after bready");
endtask

// one AXI4-Lite read, arvalid probes arready while rready is held low
task automatic read_word(
    input  string                     name,
    input  board_bus_pkg::bus_addr_t  addr,
    input  int                        hold,
    output board_bus_pkg::bus_data_t  data,
    output board_bus_pkg::axi_resp_t  resp
);
    int lat;
    int tries;
    board_bus_pkg::bus_data_t held_data;
    board_bus_pkg::axi_resp_t held_resp;
    @(negedge clock_50);
    araddr  = addr;
    arvalid = 1'b1;
    tries   = 0;
    #1;
    while (!arready) begin
        if (tries == TIMEOUT) report_stall(name, "read address never accepted");
        @(negedge clock_50);
        #1;
        tries++;
    end
    @(negedge clock_50);
    arvalid = 1'b0;
    lat     = 0;
    while (!rvalid) begin
        if (lat == TIMEOUT) report_stall(name, "read data never came");
        @(negedge clock_50);
        lat++;
    end
    check_word($sformatf("%s latency", name), 32'd3, 32'(lat));
    held_data = rdata;
    held_resp = rresp;
    // second request must wait behind the pending data
    if (hold > 0) arvalid = 1'b1;
    repeat (hold) begin
        @(negedge clock_50);
        assert (rvalid) else report_stall(name, "rvalid dropped while rready was low");
        assert (!arready) else report_stall(name, "arready rose with read data pending");
        check_word($sformatf("%s held rdata", name), held_data, rdata);
        check_resp($sformatf("%s held rresp", name), held_resp, rresp);
    end
    data    = rdata;
    resp    = rresp;
    arvalid = 1'b0;
    rready  = 1'b1;
    @(negedge clock_50);
    rready = 1'b0;
    assert (!rvalid) else report_stall(name, "rvalid stayed high after rready");
endtask

`endif

/* verif/board_bus_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "board_bus_params.svh"

module board_bus_tb;

    // cycles any single wait may take
    localparam int TIMEOUT = 64;

    logic                      clock_50 = 1'b0;
    logic                      key0;
    board_bus_pkg::bus_addr_t  awaddr;
    logic                      awvalid;
    logic                      awready;
    board_bus_pkg::bus_data_t  wdata;
    board_bus_pkg::bus_strb_t  wstrb;
    logic                      wvalid;
    logic                      wready;
    board_bus_pkg::axi_resp_t  bresp;
    logic                      bvalid;
    logic                      bready;
    board_bus_pkg::bus_addr_t  araddr;
    logic                      arvalid;
    logic                      arready;
    board_bus_pkg::bus_data_t  rdata;
    board_bus_pkg::axi_resp_t  rresp;
    logic                      rvalid;
    logic                      rready;
    logic                      key_strobe;
    board_bus_pkg::key_code_t  key_code_in;
    logic                      key_irq;
    logic                      sd_byte_valid;
    logic [7:0]                sd_byte;
    logic                      sec_avail;

    int seed;
    int error_count;
    // reference contents
    board_bus_pkg::bus_data_t   ram_model [0:`BB_RAM_WORDS-1];
    logic [7:0]                 sec_model [0:`BB_SEC_BYTES-1];
    board_bus_pkg::ram_index_t  written [$];

    board_bus_top u_dut (.*);

    always #5 clock_50 = ~clock_50;

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        error_count++;
        $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        $display("ERRORS FOUND");
        $fatal(1, "value check failed");
    endtask

    task automatic report_stall(input string name, input string what);
        error_count++;
        $display("%s: %s", name, what);
        $display("ERRORS FOUND");
        $fatal(1, "protocol or timeout failure");
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else report_mismatch(name, expected, actual);
    endtask

    task automatic check_resp(input string name, input board_bus_pkg::axi_resp_t expected,
                              input board_bus_pkg::axi_resp_t actual);
        assert (actual === expected) else report_mismatch(name, 32'(expected), 32'(actual));
    endtask

    `include "axil_bfm_tasks.svh"

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    // strobed lanes take the new byte, the rest keep the old one
    function automatic board_bus_pkg::bus_data_t merge_lanes(
        input board_bus_pkg::bus_data_t old_word,
        input board_bus_pkg::bus_data_t new_word,
        input board_bus_pkg::bus_strb_t strb
    );
        board_bus_pkg::bus_data_t result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) result[8*b +: 8] = new_word[8*b +: 8];
        end
        return result;
    endfunction

    // one-cycle valid pulse, then a low cycle for the edge detector
    task automatic feed_sector_byte(input logic [7:0] value);
        @(negedge clock_50);
        sd_byte       = value;
        sd_byte_valid = 1'b1;
        @(negedge clock_50);
        sd_byte_valid = 1'b0;
        @(negedge clock_50);
    endtask

    initial begin
        board_bus_pkg::bus_data_t  data;
        board_bus_pkg::axi_resp_t  resp;
        board_bus_pkg::bus_addr_t  addr;
        board_bus_pkg::bus_strb_t  strb;
        board_bus_pkg::ram_index_t idx;
        board_bus_pkg::key_code_t  code;
        logic [31:0]               r;
        int                        hold;
        int                        tries;
        seed          = 32'h77c2;
        error_count   = 0;
        key0          = 1'b0;
        awaddr        = '0;
        awvalid       = 1'b0;
        wdata         = '0;
        wstrb         = '0;
        wvalid        = 1'b0;
        bready        = 1'b0;
        araddr        = '0;
        arvalid       = 1'b0;
        rready        = 1'b0;
        key_strobe    = 1'b0;
        key_code_in   = '0;
        sd_byte_valid = 1'b0;
        sd_byte       = '0;
        repeat (2) @(negedge clock_50);
        key0 = 1'b1;

        // outputs quiet after reset
        @(negedge clock_50);
        check_word("reset outputs", 32'd0,
                   32'({awready, wready, arready, bvalid, rvalid, key_irq, sec_avail}));

        // RAM, full word then a random lane mix
        for (int i = 0; i < 24; i++) begin
            r    = next_random();
            idx  = r[9:0];
            addr = `BB_RAM_BASE + {4'b0000, idx, 2'b00};
            data = next_random();
            write_word("ram full write", addr, data, 4'hf, 0, resp);
            check_resp("ram full write resp", `BB_RESP_OKAY, resp);
            ram_model[idx] = data;
            data = next_random();
            r    = next_random();
            strb = r[3:0];
            write_word("ram lane write", addr, data, strb, 0, resp);
            check_resp("ram lane write resp", `BB_RESP_OKAY, resp);
            ram_model[idx] = merge_lanes(ram_model[idx], data, strb);
            read_word("ram read", addr, 0, data, resp);
            check_word("ram read", ram_model[idx], data);
            check_resp("ram read resp", `BB_RESP_OKAY, resp);
            written.push_back(idx);
        end
        // later writes may hit earlier words
        foreach (written[k]) begin
            read_word("ram reread", {4'b0000, written[k], 2'b00}, 0, data, resp);
            check_word("ram reread", ram_model[written[k]], data);
        end

        // holes in the map
        read_word("unmapped read", 16'h1000, 0, data, resp);
        check_resp("unmapped read resp", `BB_RESP_DECERR, resp);
        check_word("unmapped read data", 32'd0, data);
        read_word("unmapped read", 16'h3804, 0, data, resp);
        check_resp("unmapped read resp", `BB_RESP_DECERR, resp);
        check_word("unmapped read data", 32'd0, data);
        write_word("unmapped write", 16'h4000, next_random(), 4'hf, 0, resp);
        check_resp("unmapped write resp", `BB_RESP_DECERR, resp);

        // keyboard code and interrupt
        r    = next_random();
        code = r[7:0];
        if (code == 8'h00) code = 8'h5a;
        @(negedge clock_50);
        key_code_in = code;
        key_strobe  = 1'b1;
        tries       = 0;
        while (!key_irq) begin
            if (tries == TIMEOUT) report_stall("keyboard", "key_irq never rose after a strobe");
            @(negedge clock_50);
            tries++;
        end
        key_strobe = 1'b0;
        read_word("key code read", `BB_KEY_CODE_ADDR, 0, data, resp);
        check_word("key code read", 32'(code), data);
        check_resp("key code resp", `BB_RESP_OKAY, resp);
        check_word("key irq held", 32'd1, 32'(key_irq));
        write_word("key ack write", `BB_KEY_ACK_ADDR, 32'h1, 4'hf, 0, resp);
        check_resp("key ack resp", `BB_RESP_OKAY, resp);
        check_word("key irq after ack", 32'd0, 32'(key_irq));
        // code zero is no key
        @(negedge clock_50);
        key_code_in = 8'h00;
        key_strobe  = 1'b1;
        repeat (4) @(negedge clock_50);
        check_word("key irq for code zero", 32'd0, 32'(key_irq));
        key_strobe = 1'b0;

        // full sector from the byte stream
        for (int i = 0; i < `BB_SEC_BYTES; i++) begin
            r            = next_random();
            sec_model[i] = r[7:0];
            feed_sector_byte(r[7:0]);
            if (i < `BB_SEC_BYTES - 1) begin
                check_word("sec_avail before sector end", 32'd0, 32'(sec_avail));
            end
        end
        tries = 0;
        while (!sec_avail) begin
            if (tries == TIMEOUT) report_stall("sector", "sec_avail never rose");
            @(negedge clock_50);
            tries++;
        end
        read_word("sector flag read", `BB_SEC_AVAIL_ADDR, 0, data, resp);
        check_word("sector flag read", 32'd1, data);
        check_resp("sector flag resp", `BB_RESP_OKAY, resp);
        for (int i = 0; i < `BB_SEC_BYTES; i++) begin
            read_word("sector byte read", `BB_SEC_BASE + 16'(i * 4), 0, data, resp);
            check_word("sector byte read", 32'(sec_model[i]), data);
        end
        // next sector starts over at index 0
        r = next_random();
        feed_sector_byte(r[7:0]);
        tries = 0;
        while (sec_avail) begin
            if (tries == TIMEOUT) report_stall("sector", "sec_avail stayed high on a new sector");
            @(negedge clock_50);
            tries++;
        end
        read_word("sector wrap read", `BB_SEC_BASE, 0, data, resp);
        check_word("sector wrap read", 32'(r[7:0]), data);

        // random back-pressure on both response channels
        for (int i = 0; i < 8; i++) begin
            r    = next_random();
            idx  = r[9:0];
            addr = {4'b0000, idx, 2'b00};
            data = next_random();
            r    = next_random();
            hold = 1 + int'(r[2:0]);
            write_word("held write", addr, data, 4'hf, hold, resp);
            check_resp("held write resp", `BB_RESP_OKAY, resp);
            ram_model[idx] = data;
            hold = 1 + int'(r[5:3]);
            read_word("held read", addr, hold, data, resp);
            check_word("held read", ram_model[idx], data);
            check_resp("held read resp", `BB_RESP_OKAY, resp);
        end

        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* board_bus.f */
+incdir+logic
+incdir+verif
logic/board_bus_pkg.sv
logic/axil_slave_port.sv
logic/memory_map_router.sv
logic/data_ram.sv
logic/key_irq_latch.sv
logic/sector_capture.sv
logic/sector_cache.sv
logic/board_bus_top.sv
verif/board_bus_tb.sv

/* Makefile */
TOP := board_bus_tb

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f board_bus.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
